//--- Makefile
TOP  = tb_eeprom_ctrl
SRCS = eeprom_defs.svh eeprom_pkg.sv eeprom_req_stage.sv eeprom_byte_seq.sv \
       i2c_bit_engine.sv eeprom_ctrl_top.sv tb_eeprom_model.sv tb_eeprom_ctrl.sv

.PHONY: run clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

# rebuilt only when a source or the file list changes
obj_dir/V$(TOP): $(SRCS) sim.f
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

//--- eeprom_byte_seq.sv
`include "eeprom_defs.svh"

module eeprom_byte_seq (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 txn_valid,
    output logic                 txn_ready,
    input  logic                 txn_is_read,
    input  eeprom_pkg::ee_addr_t txn_addr,
    input  eeprom_pkg::ee_data_t txn_wdata,
    output logic                 txn_done,
    output eeprom_pkg::ee_data_t txn_rdata,
    output logic                 txn_nack,
    output logic                 op_valid,
    input  logic                 op_ready,
    output eeprom_pkg::bus_op_e  op_code,
    output eeprom_pkg::ee_data_t op_byte,
    input  logic                 op_done,
    input  eeprom_pkg::ee_data_t op_rbyte,
    input  logic                 op_nack
);

    eeprom_pkg::seq_state_e state;
    logic                   t_is_read;
    eeprom_pkg::ee_addr_t   t_addr;
    eeprom_pkg::ee_data_t   t_wdata;

    assign txn_ready = (state == eeprom_pkg::seq_idle);

    // one bus operation per state
    always_comb begin
        op_code = eeprom_pkg::op_write;
        op_byte = '0;
        case (state)
            eeprom_pkg::seq_start,
            eeprom_pkg::seq_restart: op_code = eeprom_pkg::op_start;
            eeprom_pkg::seq_ctrl_wr: op_byte = {`EE_DEV_CODE, t_addr[`EE_ADDR_W-1:8], 1'b0};
            eeprom_pkg::seq_addr_wr: op_byte = t_addr[7:0];
            eeprom_pkg::seq_data_wr: op_byte = t_wdata;
            eeprom_pkg::seq_ctrl_rd: op_byte = {`EE_DEV_CODE, t_addr[`EE_ADDR_W-1:8], 1'b1};
            eeprom_pkg::seq_data_rd: op_code = eeprom_pkg::op_read_nack;  // single byte
            default:                 op_code = eeprom_pkg::op_stop;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= eeprom_pkg::seq_idle;
            op_valid <= 1'b0;
            txn_done <= 1'b0;
            txn_nack <= 1'b0;
        end else begin
            txn_done <= 1'b0;
            if (op_valid && op_ready)
                op_valid <= 1'b0;
            case (state)
                eeprom_pkg::seq_idle: begin
                    if (txn_valid) begin
                        txn_nack <= 1'b0;
                        op_valid <= 1'b1;
                        state    <= eeprom_pkg::seq_start;
                    end
                end
                eeprom_pkg::seq_start: begin
                    if (op_done) begin
                        op_valid <= 1'b1;
                        state    <= eeprom_pkg::seq_ctrl_wr;
                    end
                end
                eeprom_pkg::seq_ctrl_wr, eeprom_pkg::seq_ctrl_rd: begin
                    if (op_done) begin
                        op_valid <= 1'b1;
                        if (op_nack) begin
                            txn_nack <= 1'b1;
                            state    <= eeprom_pkg::seq_stop;  // skip the rest
                        end else if (state == eeprom_pkg::seq_ctrl_wr)
                            state <= eeprom_pkg::seq_addr_wr;
                        else
                            state <= eeprom_pkg::seq_data_rd;
                    end
                end
                eeprom_pkg::seq_addr_wr: begin
                    if (op_done) begin
                        op_valid <= 1'b1;
                        if (op_nack) begin
                            txn_nack <= 1'b1;
                            state    <= eeprom_pkg::seq_stop;
                        end else if (t_is_read)
                            state <= eeprom_pkg::seq_restart;
                        else
                            state <= eeprom_pkg::seq_data_wr;
                    end
                end
                eeprom_pkg::seq_data_wr: begin
                    if (op_done) begin
                        op_valid <= 1'b1;
                        txn_nack <= op_nack;
                        state    <= eeprom_pkg::seq_stop;
                    end
                end
                eeprom_pkg::seq_restart: begin
                    if (op_done) begin
                        op_valid <= 1'b1;
                        state    <= eeprom_pkg::seq_ctrl_rd;
                    end
                end
                eeprom_pkg::seq_data_rd: begin
                    if (op_done) begin
                        op_valid <= 1'b1;
                        state    <= eeprom_pkg::seq_stop;
                    end
                end
                eeprom_pkg::seq_stop: begin
                    if (op_done)
                        state <= eeprom_pkg::seq_done;
                end
                default: begin
                    txn_done <= 1'b1;  // bus already released
                    state    <= eeprom_pkg::seq_idle;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (txn_valid && txn_ready) begin
            t_is_read <= txn_is_read;
            t_addr    <= txn_addr;
            t_wdata   <= txn_wdata;
        end
        if (state == eeprom_pkg::seq_data_rd && op_done)
            txn_rdata <= op_rbyte;
    end

endmodule

//--- eeprom_ctrl_top.sv
`include "eeprom_defs.svh"

module eeprom_ctrl_top (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_data_t wdata,
    output logic                 ack,
    output eeprom_pkg::ee_data_t rdata,
    output logic                 nack_err,
    output logic                 scl,
    output logic                 sda_oe,  // high pulls sda low
    input  logic                 sda_in
);

    // request stage to sequencer
    logic                 txn_valid;
    logic                 txn_ready;
    logic                 txn_is_read;
    eeprom_pkg::ee_addr_t txn_addr;
    eeprom_pkg::ee_data_t txn_wdata;
    logic                 txn_done;
    eeprom_pkg::ee_data_t txn_rdata;
    logic                 txn_nack;

    // sequencer to bit engine
    logic                 op_valid;
    logic                 op_ready;
    eeprom_pkg::bus_op_e  op_code;
    eeprom_pkg::ee_data_t op_byte;
    logic                 op_done;
    eeprom_pkg::ee_data_t op_rbyte;
    logic                 op_nack;

    eeprom_req_stage u_req (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .rdata       (rdata),
        .nack_err    (nack_err),
        .txn_valid   (txn_valid),
        .txn_ready   (txn_ready),
        .txn_is_read (txn_is_read),
        .txn_addr    (txn_addr),
        .txn_wdata   (txn_wdata),
        .txn_done    (txn_done),
        .txn_rdata   (txn_rdata),
        .txn_nack    (txn_nack)
    );

    eeprom_byte_seq u_seq (
        .CLK         (CLK),
        .RESET       (RESET),
        .txn_valid   (txn_valid),
        .txn_ready   (txn_ready),
        .txn_is_read (txn_is_read),
        .txn_addr    (txn_addr),
        .txn_wdata   (txn_wdata),
        .txn_done    (txn_done),
        .txn_rdata   (txn_rdata),
        .txn_nack    (txn_nack),
        .op_valid    (op_valid),
        .op_ready    (op_ready),
        .op_code     (op_code),
        .op_byte     (op_byte),
        .op_done     (op_done),
        .op_rbyte    (op_rbyte),
        .op_nack     (op_nack)
    );

    i2c_bit_engine u_bit (
        .CLK      (CLK),
        .RESET    (RESET),
        .op_valid (op_valid),
        .op_ready (op_ready),
        .op_code  (op_code),
        .op_byte  (op_byte),
        .op_done  (op_done),
        .op_rbyte (op_rbyte),
        .op_nack  (op_nack),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

endmodule

//--- eeprom_defs.svh
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

`define EE_ADDR_W   11       // 2 KB, three block bits plus word address
`define EE_DATA_W   8
`define EE_DEV_CODE 4'b1010  // upper nibble of the control byte

// bus timing
`define EE_QTR      1        // CLK cycles per quarter SCL period
`define EE_QCNT_W   8        // quarter counter width, EE_QTR must fit

`endif

//--- eeprom_pkg.sv
`include "eeprom_defs.svh"

package eeprom_pkg;

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [`EE_DATA_W-1:0] ee_data_t;
    typedef logic [`EE_QCNT_W-1:0] ee_qcnt_t;

    // one entry per bus operation, op_start also serves as repeated start
    typedef enum logic [2:0] {
        op_start, op_stop, op_write, op_read_ack, op_read_nack
    } bus_op_e;

    typedef enum logic [1:0] {
        req_idle, req_busy, req_hold
    } req_state_e;

    typedef enum logic [3:0] {
        seq_idle, seq_start, seq_ctrl_wr, seq_addr_wr, seq_data_wr,
        seq_restart, seq_ctrl_rd, seq_data_rd, seq_stop, seq_done
    } seq_state_e;

    typedef enum logic [2:0] {
        bit_idle, bit_start_a, bit_start_b, bit_shift, bit_ack, bit_stop_a, bit_stop_b
    } bit_state_e;

endpackage

//--- eeprom_req_stage.sv
`include "eeprom_defs.svh"

module eeprom_req_stage (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_data_t wdata,
    output logic                 ack,
    output eeprom_pkg::ee_data_t rdata,
    output logic                 nack_err,
    output logic                 txn_valid,
    input  logic                 txn_ready,
    output logic                 txn_is_read,
    output eeprom_pkg::ee_addr_t txn_addr,
    output eeprom_pkg::ee_data_t txn_wdata,
    input  logic                 txn_done,
    input  eeprom_pkg::ee_data_t txn_rdata,
    input  logic                 txn_nack
);

    eeprom_pkg::req_state_e state;
    logic                   take;
    logic                   finish;

    assign take   = (state == eeprom_pkg::req_idle) && (wr || rd);
    assign finish = (state == eeprom_pkg::req_busy) && txn_done;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= eeprom_pkg::req_idle;
            txn_valid <= 1'b0;
            ack       <= 1'b0;
            nack_err  <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                eeprom_pkg::req_idle: begin
                    if (take) begin
                        txn_valid <= 1'b1;
                        state     <= eeprom_pkg::req_busy;
                    end
                end
                eeprom_pkg::req_busy: begin
                    if (txn_valid && txn_ready)
                        txn_valid <= 1'b0;
                    if (finish) begin
                        ack      <= 1'b1;
                        nack_err <= txn_nack;
                        state    <= eeprom_pkg::req_hold;
                    end
                end
                default: begin
                    // wait for the requester to let go of wr/rd
                    if (!wr && !rd)
                        state <= eeprom_pkg::req_idle;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            txn_is_read <= !wr;  // write wins
            txn_addr    <= addr;
            txn_wdata   <= wdata;
        end
        if (finish)
            rdata <= txn_rdata;
    end

endmodule

//--- i2c_bit_engine.sv
`include "eeprom_defs.svh"

module i2c_bit_engine (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 op_valid,
    output logic                 op_ready,
    input  eeprom_pkg::bus_op_e  op_code,
    input  eeprom_pkg::ee_data_t op_byte,
    output logic                 op_done,
    output eeprom_pkg::ee_data_t op_rbyte,
    output logic                 op_nack,
    output logic                 scl,
    output logic                 sda_oe,
    input  logic                 sda_in
);

    eeprom_pkg::bit_state_e state;
    eeprom_pkg::ee_qcnt_t   qcnt;
    eeprom_pkg::ee_data_t   sreg;
    logic [1:0]             ph;        // quarter within a bit
    logic [2:0]             bcnt;
    logic                   rd_mode;
    logic                   ack_drive; // master acks after a read byte
    logic                   tick;

    assign tick     = (qcnt == eeprom_pkg::ee_qcnt_t'(`EE_QTR - 1));
    assign op_ready = (state == eeprom_pkg::bit_idle);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= eeprom_pkg::bit_idle;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            op_done <= 1'b0;
            qcnt    <= '0;
            ph      <= '0;
            bcnt    <= '0;
        end else begin
            op_done <= 1'b0;
            if (state == eeprom_pkg::bit_idle) begin
                qcnt <= '0;
                ph   <= '0;
                bcnt <= '0;
                if (op_valid) begin
                    scl       <= 1'b0;
                    sreg      <= op_byte;
                    rd_mode   <= (op_code == eeprom_pkg::op_read_ack) ||
                                 (op_code == eeprom_pkg::op_read_nack);
                    ack_drive <= (op_code == eeprom_pkg::op_read_ack);
                    case (op_code)
                        eeprom_pkg::op_start: begin
                            sda_oe <= 1'b0;  // sda high before scl rises
                            state  <= eeprom_pkg::bit_start_a;
                        end
                        eeprom_pkg::op_stop: begin
                            sda_oe <= 1'b1;
                            state  <= eeprom_pkg::bit_stop_a;
                        end
                        eeprom_pkg::op_write: begin
                            sda_oe <= ~op_byte[7];  // msb first
                            state  <= eeprom_pkg::bit_shift;
                        end
                        default: begin
                            sda_oe <= 1'b0;
                            state  <= eeprom_pkg::bit_shift;
                        end
                    endcase
                end
            end else if (!tick) begin
                qcnt <= qcnt + 1'b1;
            end else begin
                qcnt <= '0;
                ph   <= ph + 2'd1;
                case (state)
                    eeprom_pkg::bit_start_a, eeprom_pkg::bit_stop_a: begin
                        if (ph == 2'd0)
                            scl <= 1'b1;
                        else begin
                            ph     <= '0;
                            sda_oe <= (state == eeprom_pkg::bit_start_a); // edge with scl high
                            state  <= (state == eeprom_pkg::bit_start_a) ?
                                      eeprom_pkg::bit_start_b : eeprom_pkg::bit_stop_b;
                        end
                    end
                    eeprom_pkg::bit_start_b, eeprom_pkg::bit_stop_b: begin
                        if (ph == 2'd0)
                            scl <= (state == eeprom_pkg::bit_stop_b);
                        else begin
                            op_done <= 1'b1;
                            state   <= eeprom_pkg::bit_idle;
                        end
                    end
                    default: begin
                        // shift and ack bits, scl high in quarters 1 and 2
                        case (ph)
                            2'd0: scl <= 1'b1;
                            2'd1: begin
                                if (state == eeprom_pkg::bit_shift)
                                    sreg <= {sreg[6:0], sda_in};
                                else
                                    op_nack <= ~rd_mode & sda_in;
                            end
                            2'd2: scl <= 1'b0;
                            default: begin
                                if (state == eeprom_pkg::bit_ack) begin
                                    sda_oe   <= 1'b0;
                                    op_rbyte <= sreg;
                                    op_done  <= 1'b1;
                                    state    <= eeprom_pkg::bit_idle;
                                end else if (bcnt == 3'd7) begin
                                    sda_oe <= rd_mode & ack_drive;
                                    state  <= eeprom_pkg::bit_ack;
                                end else begin
                                    bcnt   <= bcnt + 3'd1;
                                    sda_oe <= ~rd_mode & ~sreg[7];
                                end
                            end
                        endcase
                    end
                endcase
            end
        end
    end

endmodule

//--- sim.f
+incdir+.
eeprom_pkg.sv
eeprom_req_stage.sv
eeprom_byte_seq.sv
i2c_bit_engine.sv
eeprom_ctrl_top.sv
tb_eeprom_model.sv
tb_eeprom_ctrl.sv

//--- tb_eeprom_ctrl.sv
`include "eeprom_defs.svh"

module tb_eeprom_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACK_TIMEOUT = 1000;  // CLK cycles per request
    localparam int MEM_SIZE    = 1 << `EE_ADDR_W;

    logic                 CLK;
    logic                 RESET;
    logic                 wr;
    logic                 rd;
    eeprom_pkg::ee_addr_t addr;
    eeprom_pkg::ee_data_t wdata;
    logic                 ack;
    eeprom_pkg::ee_data_t rdata;
    logic                 nack_err;
    logic                 scl;
    logic                 sda_oe;
    logic                 sda;
    logic                 model_pull;
    logic                 no_ack;
    logic                 frame_err;

    eeprom_pkg::ee_data_t ref_mem [0:MEM_SIZE-1];
    integer               seed = 32'hce29;
    int                   req_count = 0;
    int                   ack_count = 0;

    assign sda = ~(sda_oe | model_pull);  // pulled up unless someone drives low

    eeprom_ctrl_top dut0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .ack      (ack),
        .rdata    (rdata),
        .nack_err (nack_err),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda)
    );

    tb_eeprom_model model0 (
        .CLK       (CLK),
        .scl       (scl),
        .sda       (sda),
        .no_ack    (no_ack),
        .sda_pull  (model_pull),
        .frame_err (frame_err)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        if (RESET === 1'b0 && ack === 1'b1)
            ack_count <= ack_count + 1;
    end

    always @(posedge CLK) begin
        if (frame_err === 1'b1) begin
            $display("Testbench failed");
            $fatal(1, "the EEPROM model saw an illegal bus sequence");
        end
    end

    function automatic eeprom_pkg::ee_data_t fill_byte(input int a);
        return eeprom_pkg::ee_data_t'(a ^ (a >> 3) ^ 8'h5a);  // all address bits matter
    endfunction

    task automatic check(input logic cond, input string msg);
        assert (cond) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            $display("Testbench failed");
            $fatal(1, "stopping on the first failed check");
        end
    endtask

    task automatic wait_for_ack(output eeprom_pkg::ee_data_t data, output logic err);
        int cycles;
        cycles = 0;
        @(posedge CLK);
        while (ack !== 1'b1) begin
            if (cycles >= ACK_TIMEOUT) begin
                $display("no ack within %0d cycles, time %0t", ACK_TIMEOUT, $time);
                $display("Testbench failed");
                $fatal(1, "request timed out");
            end
            cycles++;
            @(posedge CLK);
        end
        data = rdata;
        err  = nack_err;
        wr <= 1'b0;
        rd <= 1'b0;
        req_count++;
        @(posedge CLK);
        check(ack === 1'b0, "ack longer than one cycle");
    endtask

    task automatic do_write(input eeprom_pkg::ee_addr_t a, input eeprom_pkg::ee_data_t d,
                            input logic with_rd, output logic err);
        eeprom_pkg::ee_data_t rd_dummy;
        @(posedge CLK);
        wr    <= 1'b1;
        rd    <= with_rd;
        addr  <= a;
        wdata <= d;
        wait_for_ack(rd_dummy, err);
    endtask

    task automatic do_read(input eeprom_pkg::ee_addr_t a, output eeprom_pkg::ee_data_t d,
                           output logic err);
        @(posedge CLK);
        rd   <= 1'b1;
        addr <= a;
        wait_for_ack(d, err);
    endtask

    task automatic read_and_compare(input eeprom_pkg::ee_addr_t a);
        eeprom_pkg::ee_data_t got;
        logic                 err;
        do_read(a, got, err);
        check(err === 1'b0, $sformatf("nack_err on read of %h", a));
        check(got === ref_mem[a], $sformatf("read %h from %h, expected %h", got, a, ref_mem[a]));
    endtask

    task automatic idle_after_reset();
        for (int i = 0; i < 8; i++) begin
            @(posedge CLK);
            check(ack === 1'b0 && nack_err === 1'b0, "ack or nack_err high after reset");
            check(scl === 1'b1 && sda_oe === 1'b0, "bus not released after reset");
        end
    endtask

    task automatic write_then_read();
        eeprom_pkg::ee_addr_t a;
        eeprom_pkg::ee_data_t d;
        logic                 err;
        a = 11'h123;
        d = eeprom_pkg::ee_data_t'($random(seed));
        do_write(a, d, 1'b0, err);
        check(err === 1'b0, "nack_err on a plain write");
        ref_mem[a] = d;
        read_and_compare(a);
    endtask

    task automatic blocks_round_trip();
        eeprom_pkg::ee_addr_t addrs [8];
        eeprom_pkg::ee_data_t d;
        logic [7:0]           w;
        logic                 err;
        int                   k;
        w = 8'($random(seed));  // same word address in every block
        for (int b = 0; b < 8; b++) begin
            addrs[b] = {3'(b), w};
            d        = eeprom_pkg::ee_data_t'($random(seed));
            do_write(addrs[b], d, 1'b0, err);
            check(err === 1'b0, $sformatf("nack_err on write to block %0d", b));
            ref_mem[addrs[b]] = d;
        end
        for (int b = 0; b < 8; b++) begin
            k = (5 * b + 5) % 8;  // shuffled block order
            read_and_compare(addrs[k]);
            read_and_compare({addrs[k][10:8], ~w});  // unwritten word in the same block
        end
    endtask

    task automatic wr_and_rd_together();
        eeprom_pkg::ee_addr_t a;
        eeprom_pkg::ee_data_t d;
        logic                 err;
        a = 11'h6b4;
        d = ~ref_mem[a];
        do_write(a, d, 1'b1, err);
        check(err === 1'b0, "nack_err with wr and rd raised together");
        ref_mem[a] = d;
        read_and_compare(a);
    endtask

    task automatic missing_ack();
        eeprom_pkg::ee_addr_t a;
        eeprom_pkg::ee_data_t d;
        logic                 err;
        a = 11'h123;
        d = ~ref_mem[a];
        @(posedge CLK);
        no_ack <= 1'b1;
        do_write(a, d, 1'b0, err);
        check(err === 1'b1, "missing acknowledge not reported");
        for (int i = 0; i < 4; i++) begin
            check(scl === 1'b1 && sda_oe === 1'b0, "bus not released after missing acknowledge");
            @(posedge CLK);
        end
        no_ack <= 1'b0;
        read_and_compare(a);  // old value, nothing was stored
    endtask

    initial begin
        CLK = 1'b0;
        RESET  <= 1'b1;
        wr     <= 1'b0;
        rd     <= 1'b0;
        addr   <= '0;
        wdata  <= '0;
        no_ack <= 1'b0;
        for (int i = 0; i < MEM_SIZE; i++) begin
            ref_mem[i]    = fill_byte(i);
            model0.mem[i] = fill_byte(i);
        end
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;

        idle_after_reset();
        write_then_read();
        blocks_round_trip();
        wr_and_rd_together();
        missing_ack();

        repeat (4) @(posedge CLK);
        check(ack_count == req_count, "number of acks differs from number of requests");
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- tb_eeprom_model.sv
`include "eeprom_defs.svh"

module tb_eeprom_model (
    input  logic CLK,
    input  logic scl,
    input  logic sda,
    input  logic no_ack,
    output logic sda_pull,   // high pulls sda low
    output logic frame_err
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {
        ph_idle, ph_rx, ph_ack_out, ph_tx, ph_mack, ph_done
    } phase_e;

    logic [7:0]            mem [0:(1 << `EE_ADDR_W) - 1];  // preloaded by the testbench
    phase_e                phase = ph_idle;
    logic                  prev_scl = 1'b1;
    logic                  prev_sda = 1'b1;
    logic [3:0]            bit_cnt = '0;
    logic [7:0]            shreg = '0;
    logic [7:0]            tx_byte = '0;
    logic [`EE_ADDR_W-1:0] ptr = '0;
    int                    byte_idx = 0;
    logic                  restarted = 1'b0;
    logic                  addr_set = 1'b0;
    logic                  is_read = 1'b0;
    logic                  wr_pending = 1'b0;
    logic [7:0]            wr_data = '0;

    initial begin
        sda_pull  = 1'b0;
        frame_err = 1'b0;
    end

    task automatic framing_error(input string msg);
        $display("EEPROM model at %0t: %s", $time, msg);
        frame_err = 1'b1;
    endtask

    task automatic take_start();
        if (phase == ph_idle) begin
            restarted = 1'b0;
            addr_set  = 1'b0;
        end else if (phase == ph_rx && bit_cnt <= 4'd1 && addr_set && !wr_pending && !restarted)
            restarted = 1'b1;  // random read turnaround
        else
            framing_error("start condition at an illegal point of the transfer");
        phase    = ph_rx;
        bit_cnt  = '0;
        byte_idx = 0;
    endtask

    task automatic take_stop();
        // scl rising before the stop already counted one bit
        if (phase == ph_rx && bit_cnt <= 4'd1) begin
            if (wr_pending)
                mem[ptr] = wr_data;
        end else if (phase != ph_idle && phase != ph_done)
            framing_error("stop condition inside a byte");
        phase      = ph_idle;
        sda_pull   = 1'b0;
        wr_pending = 1'b0;
        restarted  = 1'b0;
        addr_set   = 1'b0;
    endtask

    task automatic take_byte();
        if (byte_idx == 0 && shreg[7:4] != `EE_DEV_CODE)
            framing_error($sformatf("control byte %h lacks device code 1010", shreg));
        else if (no_ack)
            phase = ph_idle;  // off the bus until the next start
        else begin
            if (byte_idx == 0) begin
                if (shreg[0] != restarted)
                    framing_error("read/write bit does not fit the transfer sequence");
                if (restarted && shreg[3:1] != ptr[`EE_ADDR_W-1:8])
                    framing_error("block bits changed between write and read control bytes");
                is_read               = shreg[0];
                ptr[`EE_ADDR_W-1:8]   = shreg[3:1];
            end else if (byte_idx == 1) begin
                ptr[7:0] = shreg;
                addr_set = 1'b1;
            end else if (byte_idx == 2) begin
                wr_data    = shreg;
                wr_pending = 1'b1;
            end else
                framing_error("more than one data byte in a write");
            sda_pull = 1'b1;
            phase    = ph_ack_out;
            byte_idx++;
        end
    endtask

    // bus sampled away from the DUT's clock edge
    always @(negedge CLK) begin
        logic bus;
        bus = sda;
        if (prev_scl && scl && prev_sda && !bus)
            take_start();
        else if (prev_scl && scl && !prev_sda && bus)
            take_stop();
        else if (!prev_scl && scl) begin
            case (phase)
                ph_rx: begin
                    shreg   = {shreg[6:0], bus};
                    bit_cnt = bit_cnt + 4'd1;
                end
                ph_tx: bit_cnt = bit_cnt + 4'd1;
                ph_mack: begin
                    if (!bus)
                        framing_error("master acknowledged the read byte");
                    else
                        phase = ph_done;
                end
                default: ;
            endcase
        end else if (prev_scl && !scl) begin
            case (phase)
                ph_rx: begin
                    if (bit_cnt == 4'd8)
                        take_byte();
                end
                ph_ack_out: begin
                    bit_cnt = '0;
                    if (is_read) begin
                        tx_byte  = mem[ptr];
                        sda_pull = !tx_byte[7];
                        phase    = ph_tx;
                    end else begin
                        sda_pull = 1'b0;
                        phase    = ph_rx;
                    end
                end
                ph_tx: begin
                    if (bit_cnt == 4'd8) begin
                        sda_pull = 1'b0;  // master answers the byte
                        phase    = ph_mack;
                    end else
                        sda_pull = !tx_byte[3'd7 - bit_cnt[2:0]];
                end
                default: ;
            endcase
        end
        prev_scl = scl;
        prev_sda = bus;
    end

endmodule
